// File: sim.f
+incdir+testbench
design/decode_pkg.sv
design/instr_fields.sv
design/hazard_detect.sv
design/reg_file.sv
design/decode_stage_reg.sv
design/decode_top.sv
testbench/tb_decode.sv

// File: testbench/decode_model.svh
// decode reference model

// one registered slot as execute sees it
typedef struct {
    reg_addr_t dest;
    op_key_t   opcode;
    imm_t      imm;
    uimm_t     uimm;
    reg_addr_t rs1;
    xlen_t     data_a;
    xlen_t     data_b;
    xlen_t     pc;
    instr_t    instr;
    logic      stall;
} slot_t;

// register file image, entry zero is never written
xlen_t shadow [NUM_REGS];

task automatic shadow_write(logic en, reg_addr_t addr, xlen_t data);
    if (en && addr != '0) begin
        shadow[addr] = data;
    end
endtask

// next slot from the current one and this cycle's inputs
function automatic slot_t predict_slot(slot_t cur, instr_t ins, xlen_t ins_pc,
                                       reg_addr_t alu_d, reg_addr_t mem_d,
                                       reg_addr_t wb_d, logic alu_st,
                                       logic flush_now, logic flush_last);
    slot_t      nxt;
    logic [2:0] use_bits;
    reg_addr_t  s1;
    reg_addr_t  s2;
    uimm_t      up;
    logic       hz;
    nxt = cur;
    // {rd, rs1, rs2} per class
    // fence and unknown opcodes use nothing
    case (opcode_class_t'(ins[6:0]))
        OPC_R, OPC_R_WORD:                         use_bits = 3'b111;
        OPC_JALR, OPC_LOAD, OPC_I_ARITH,
        OPC_I_WORD, OPC_SYSTEM:                    use_bits = 3'b110;
        OPC_STORE, OPC_BRANCH:                     use_bits = 3'b011;
        OPC_LUI, OPC_AUIPC, OPC_JAL:               use_bits = 3'b100;
        default:                                   use_bits = 3'b000;
    endcase
    case (opcode_class_t'(ins[6:0]))
        OPC_LUI, OPC_AUIPC: up = ins[31:12];
        OPC_JAL:            up = {ins[31], ins[19:12], ins[20], ins[30:21]};
        default:            up = '0;
    endcase
    s1 = use_bits[1] ? ins[19:15] : '0;
    s2 = use_bits[0] ? ins[24:20] : '0;
    // x0 never collides, alu slot exempt while it holds a store
    hz = (s1 != '0 && (s1 == mem_d || s1 == wb_d || (!alu_st && s1 == alu_d)))
      || (s2 != '0 && (s2 == mem_d || s2 == wb_d || (!alu_st && s2 == alu_d)));
    nxt.stall = hz;
    if (hz || flush_now || flush_last) begin
        // bubble, payload holds
        nxt.dest   = '0;
        nxt.opcode = BUBBLE_OP;
    end else begin
        nxt.dest   = use_bits[2] ? ins[11:7] : '0;
        nxt.opcode = {ins[14:12], ins[6:0]};
        nxt.imm    = ins[31:20];
        nxt.uimm   = up;
        nxt.rs1    = s1;
        nxt.data_a = (s1 == '0) ? '0 : shadow[s1];
        nxt.data_b = (s2 == '0) ? '0 : shadow[s2];
        nxt.pc     = ins_pc;
        nxt.instr  = ins;
    end
    return nxt;
endfunction

// typed compares
task automatic check_xlen(string name, xlen_t got, xlen_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
endtask
task automatic check_reg_addr(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask
task automatic check_op_key(string name, op_key_t got, op_key_t exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask
task automatic check_imm(string name, imm_t got, imm_t exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask
task automatic check_uimm(string name, uimm_t got, uimm_t exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask
task automatic check_instr(string name, instr_t got, instr_t exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask
task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_mismatch(name, xlen_t'(got), xlen_t'(exp));
endtask

// File: testbench/tb_decode.sv
// decode stage testbench
module tb_decode;
    import decode_pkg::*;

    // dut inputs
    logic      clk;
    logic      reset;
    instr_t    instr;
    xlen_t     pc;
    logic      flush;
    logic      wr_en;
    reg_addr_t wr_addr;
    xlen_t     wr_data;
    reg_addr_t alu_dest;
    logic      alu_is_store;
    reg_addr_t mem_dest;
    reg_addr_t wb_dest;

    // dut outputs
    reg_addr_t reg_dest;
    op_key_t   opcode;
    imm_t      imm;
    uimm_t     uimm;
    reg_addr_t rs1_out;
    xlen_t     rd_data_a;
    xlen_t     rd_data_b;
    xlen_t     out_pc;
    instr_t    out_instr;
    logic      stall;

    `include "decode_model.svh"

    slot_t exp_slot;
    logic  check_en;
    logic  flush_last;

    opcode_class_t classes [13] = '{OPC_R, OPC_R_WORD, OPC_JALR, OPC_LOAD, OPC_I_ARITH,
                                    OPC_I_WORD, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC,
                                    OPC_JAL, OPC_FENCE, OPC_SYSTEM};

    decode_top decode_top_inst (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .pc           (pc),
        .flush        (flush),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .alu_dest     (alu_dest),
        .alu_is_store (alu_is_store),
        .mem_dest     (mem_dest),
        .wb_dest      (wb_dest),
        .reg_dest     (reg_dest),
        .opcode       (opcode),
        .imm          (imm),
        .uimm         (uimm),
        .rs1_out      (rs1_out),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .out_pc       (out_pc),
        .out_instr    (out_instr),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(string name, xlen_t got, xlen_t exp);
        $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        stop_with_failure();
    endtask

    // inputs are already on the pins, predict the edge and move to the next falling edge
    task automatic advance_cycle();
        exp_slot = predict_slot(exp_slot, instr, pc, alu_dest, mem_dest, wb_dest,
                                alu_is_store, flush, flush_last);
        shadow_write(wr_en, wr_addr, wr_data);
        flush_last = flush;
        check_en   = 1'b1;
        @(negedge clk);
    endtask

    task automatic set_dests(reg_addr_t a, reg_addr_t m, reg_addr_t w, logic st);
        alu_dest     = a;
        mem_dest     = m;
        wb_dest      = w;
        alu_is_store = st;
    endtask

    // keeps the current inputs until stall reaches the level
    task automatic wait_stall(logic level, int limit);
        int n;
        n = 0;
        while (stall !== level) begin
            if (n == limit) begin
                $display("timeout after %0d cycles waiting for stall to go %0b", limit, level);
                stop_with_failure();
            end
            advance_cycle();
            n++;
        end
    endtask

    function automatic instr_t r_type(reg_addr_t rd, reg_addr_t s1, reg_addr_t s2);
        return {7'd0, s2, s1, 3'd0, rd, OPC_R};
    endfunction

    function automatic instr_t random_instr(opcode_class_t c);
        instr_t r;
        r      = $urandom();
        r[6:0] = c;
        return r;
    endfunction

    task automatic compare_outputs();
        check_reg_addr("reg_dest", reg_dest, exp_slot.dest);
        check_op_key("opcode", opcode, exp_slot.opcode);
        check_imm("imm", imm, exp_slot.imm);
        check_uimm("uimm", uimm, exp_slot.uimm);
        check_reg_addr("rs1_out", rs1_out, exp_slot.rs1);
        check_xlen("rd_data_a", rd_data_a, exp_slot.data_a);
        check_xlen("rd_data_b", rd_data_b, exp_slot.data_b);
        check_xlen("out_pc", out_pc, exp_slot.pc);
        check_instr("out_instr", out_instr, exp_slot.instr);
        check_bit("stall", stall, exp_slot.stall);
    endtask

    // every edge after reset, once outputs have settled
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (check_en) compare_outputs();
        end
    end

    initial begin
        void'($urandom(32'h7f4c));
        reset        = 1'b1;
        instr        = '0;
        pc           = '0;
        flush        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        set_dests('0, '0, '0, 1'b0);
        check_en     = 1'b0;
        flush_last   = 1'b0;
        exp_slot     = '{default: '0};
        exp_slot.opcode = BUBBLE_OP;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit("stall", stall, 1'b0);
        check_reg_addr("reg_dest", reg_dest, '0);
        check_op_key("opcode", opcode, BUBBLE_OP);
        check_xlen("rd_data_a", rd_data_a, '0);
        check_xlen("rd_data_b", rd_data_b, '0);
        reset = 1'b0;

        // preload x1..x31 through writeback, then one plain r-type
        for (int i = 1; i < NUM_REGS; i++) begin
            wr_en   = 1'b1;
            wr_addr = reg_addr_t'(i);
            wr_data = {$urandom(), $urandom()};
            advance_cycle();
        end
        wr_en = 1'b0;
        instr = r_type(5'd7, 5'd3, 5'd5);
        advance_cycle();
        check_xlen("rd_data_a", rd_data_a, shadow[3]);
        check_xlen("rd_data_b", rd_data_b, shadow[5]);

        // all classes, nothing downstream
        for (int i = 0; i < 60; i++) begin
            instr = random_instr(classes[$urandom_range(12)]);
            pc    = pc + 64'd4;
            advance_cycle();
        end

        // x0 write dropped
        wr_en   = 1'b1;
        wr_addr = '0;
        wr_data = '1;
        advance_cycle();
        wr_en = 1'b0;
        instr = r_type(5'd6, 5'd0, 5'd0);
        advance_cycle();
        check_xlen("rd_data_a", rd_data_a, '0);

        // hazard against alu, mem and wb in turn
        instr = r_type(5'd7, 5'd9, 5'd0);
        for (int k = 0; k < 3; k++) begin
            set_dests((k == 0) ? 5'd9 : 5'd0, (k == 1) ? 5'd9 : 5'd0,
                      (k == 2) ? 5'd9 : 5'd0, 1'b0);
            wait_stall(1'b1, 4);
            check_reg_addr("reg_dest", reg_dest, '0);
            set_dests('0, '0, '0, 1'b0);
            wait_stall(1'b0, 4);
        end
        // store in alu is exempt
        set_dests(5'd9, '0, '0, 1'b1);
        advance_cycle();
        advance_cycle();
        check_bit("stall", stall, 1'b0);
        // lui has no sources, matching fields are ignored
        instr = {7'd0, 5'd9, 5'd9, 3'd0, 5'd4, OPC_LUI};
        set_dests(5'd9, 5'd9, 5'd9, 1'b0);
        advance_cycle();
        advance_cycle();
        check_bit("stall", stall, 1'b0);
        set_dests('0, '0, '0, 1'b0);

        // one flush cycle kills two slots
        instr = r_type(5'd1, 5'd2, 5'd3);
        flush = 1'b1;
        advance_cycle();
        check_op_key("opcode", opcode, BUBBLE_OP);
        flush = 1'b0;
        instr = r_type(5'd4, 5'd5, 5'd6);
        advance_cycle();
        check_op_key("opcode", opcode, BUBBLE_OP);
        instr = {7'd0, 5'd8, 5'd9, 3'b111, 5'd10, OPC_R};
        advance_cycle();
        check_op_key("opcode", opcode, {3'b111, OPC_R});
        check_reg_addr("reg_dest", reg_dest, 5'd10);

        // mixed traffic, fetch holds while stalled
        for (int i = 0; i < 400; i++) begin
            if (stall !== 1'b1) begin
                instr = random_instr(classes[$urandom_range(12)]);
                pc    = pc + 64'd4;
            end
            wr_en   = ($urandom_range(1) == 1);
            wr_addr = reg_addr_t'($urandom_range(31));
            wr_data = {$urandom(), $urandom()};
            set_dests(reg_addr_t'($urandom_range(7)), reg_addr_t'($urandom_range(7)),
                      reg_addr_t'($urandom_range(7)), $urandom_range(3) == 0);
            flush   = ($urandom_range(15) == 0);
            advance_cycle();
        end
        flush = 1'b0;
        wr_en = 1'b0;
        set_dests('0, '0, '0, 1'b0);
        advance_cycle();
        advance_cycle();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: design/decode_top.sv
// rv64i decode stage
module decode_top (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::instr_t    instr,
    input  decode_pkg::xlen_t     pc,
    input  logic                  flush,
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::xlen_t     wr_data,
    input  decode_pkg::reg_addr_t alu_dest,
    input  logic                  alu_is_store,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::reg_addr_t wb_dest,
    output decode_pkg::reg_addr_t reg_dest,
    output decode_pkg::op_key_t   opcode,
    output decode_pkg::imm_t      imm,
    output decode_pkg::uimm_t     uimm,
    output decode_pkg::reg_addr_t rs1_out,
    output decode_pkg::xlen_t     rd_data_a,
    output decode_pkg::xlen_t     rd_data_b,
    output decode_pkg::xlen_t     out_pc,
    output decode_pkg::instr_t    out_instr,
    output logic                  stall
);
    import decode_pkg::*;

    // decoded fields, combinational from instr
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t dest;
    op_key_t   op_key;
    imm_t      dec_imm;
    uimm_t     dec_uimm;

    // source operands and hazard result
    xlen_t     read_a;
    xlen_t     read_b;
    logic      hazard;

    instr_fields instr_fields_inst (
        .instr  (instr),
        .rs1    (rs1),
        .rs2    (rs2),
        .dest   (dest),
        .op_key (op_key),
        .imm    (dec_imm),
        .uimm   (dec_uimm)
    );

    // only used sources reach the compare, unused ones come in as x0
    hazard_detect hazard_detect_inst (
        .rs1          (rs1),
        .rs2          (rs2),
        .alu_dest     (alu_dest),
        .mem_dest     (mem_dest),
        .wb_dest      (wb_dest),
        .alu_is_store (alu_is_store),
        .hazard       (hazard)
    );

    // writeback port writes at the edge, reads here are this cycle's
    reg_file reg_file_inst (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (rs1),
        .rd_addr_b (rs2),
        .read_a    (read_a),
        .read_b    (read_b)
    );

    decode_stage_reg decode_stage_reg_inst (
        .clk       (clk),
        .reset     (reset),
        .hazard    (hazard),
        .flush     (flush),
        .instr     (instr),
        .pc        (pc),
        .dest      (dest),
        .rs1       (rs1),
        .op_key    (op_key),
        .imm       (dec_imm),
        .uimm      (dec_uimm),
        .read_a    (read_a),
        .read_b    (read_b),
        .reg_dest  (reg_dest),
        .opcode    (opcode),
        .imm_out   (imm),
        .uimm_out  (uimm),
        .rs1_out   (rs1_out),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .out_pc    (out_pc),
        .out_instr (out_instr),
        .stall     (stall)
    );

endmodule

// File: design/decode_stage_reg.sv
// decode to execute pipeline register
module decode_stage_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hazard,
    input  logic                  flush,
    input  decode_pkg::instr_t    instr,
    input  decode_pkg::xlen_t     pc,
    input  decode_pkg::reg_addr_t dest,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::op_key_t   op_key,
    input  decode_pkg::imm_t      imm,
    input  decode_pkg::uimm_t     uimm,
    input  decode_pkg::xlen_t     read_a,
    input  decode_pkg::xlen_t     read_b,
    output decode_pkg::reg_addr_t reg_dest,
    output decode_pkg::op_key_t   opcode,
    output decode_pkg::imm_t      imm_out,
    output decode_pkg::uimm_t     uimm_out,
    output decode_pkg::reg_addr_t rs1_out,
    output decode_pkg::xlen_t     rd_data_a,
    output decode_pkg::xlen_t     rd_data_b,
    output decode_pkg::xlen_t     out_pc,
    output decode_pkg::instr_t    out_instr,
    output logic                  stall
);
    import decode_pkg::*;

    // last cycle's flush, kills the slot after the flushed one
    logic flush_d;
    logic bubble;

    // slot is squashed by a hazard, a flush, or a flush one cycle ago
    assign bubble = hazard || flush || flush_d;

    // control side of the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_d  <= 1'b0;
            stall    <= 1'b0;
            reg_dest <= '0;
            opcode   <= BUBBLE_OP;
        end else begin
            flush_d <= flush;
            // fetch holds instr and pc while this is high
            stall   <= hazard;
            if (bubble) begin
                reg_dest <= '0;
                opcode   <= BUBBLE_OP;
            end else begin
                reg_dest <= dest;
                opcode   <= op_key;
            end
        end
    end

    // payload keeps its value through a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            imm_out   <= '0;
            uimm_out  <= '0;
            rs1_out   <= '0;
            rd_data_a <= '0;
            rd_data_b <= '0;
            out_pc    <= '0;
            out_instr <= '0;
        end else if (!bubble) begin
            imm_out   <= imm;
            uimm_out  <= uimm;
            rs1_out   <= rs1;
            rd_data_a <= read_a;
            rd_data_b <= read_b;
            out_pc    <= pc;
            out_instr <= instr;
        end
    end

    // fetch presents the same instruction again while stalled
    a_fetch_holds: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> ($stable(instr) && $stable(pc))
    ) else $error("instr or pc changed while stall was high");

    // one flush cycle squashes the current and the following slot
    a_flush_two_slots: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> (opcode == BUBBLE_OP) ##1 (opcode == BUBBLE_OP)
    ) else $error("flush did not squash two consecutive slots");

endmodule

// File: design/reg_file.sv
// integer register file
module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::xlen_t     wr_data,
    input  decode_pkg::reg_addr_t rd_addr_a,
    input  decode_pkg::reg_addr_t rd_addr_b,
    output decode_pkg::xlen_t     read_a,
    output decode_pkg::xlen_t     read_b
);
    import decode_pkg::*;

    // x0 .. x31
    xlen_t regs [NUM_REGS];

    // write port from writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // x0 is hardwired so writes to it are dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads see the value before this cycle's write
    // the hazard check stalls instead of bypassing
    always_comb begin
        if (rd_addr_a == '0) begin
            read_a = '0;
        end else begin
            read_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (rd_addr_b == '0) begin
            read_b = '0;
        end else begin
            read_b = regs[rd_addr_b];
        end
    end

endmodule

// File: design/hazard_detect.sv
// read-after-write hazard check
module hazard_detect (
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::reg_addr_t alu_dest,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::reg_addr_t wb_dest,
    input  logic                  alu_is_store,
    output logic                  hazard
);
    import decode_pkg::*;

    // per-stage match flags
    logic alu_hit;
    logic mem_hit;
    logic wb_hit;

    // a source matches a stage when both name the same nonzero register
    // x0 on the source side also covers x0 on the destination side
    function automatic logic src_match(reg_addr_t src, reg_addr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    // a store in alu has no real destination since its rd bits hold offset
    assign alu_hit = !alu_is_store &&
                     (src_match(rs1, alu_dest) || src_match(rs2, alu_dest));

    assign mem_hit = src_match(rs1, mem_dest) || src_match(rs2, mem_dest);

    // writeback still counts because its register file write lands at the edge
    assign wb_hit  = src_match(rs1, wb_dest) || src_match(rs2, wb_dest);

    assign hazard = alu_hit || mem_hit || wb_hit;

endmodule

// File: design/instr_fields.sv
// instruction field extraction
module instr_fields (
    input  decode_pkg::instr_t    instr,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::reg_addr_t dest,
    output decode_pkg::op_key_t   op_key,
    output decode_pkg::imm_t      imm,
    output decode_pkg::uimm_t     uimm
);
    import decode_pkg::*;

    // class of the instruction from the low opcode bits
    opcode_class_t op_class;

    // per-class field usage
    logic use_rs1;
    logic use_rs2;
    logic has_dest;

    // raw register fields
    reg_addr_t rs1_field;
    reg_addr_t rs2_field;
    reg_addr_t rd_field;

    assign op_class  = opcode_class_t'(instr[OPC_W-1:0]);
    assign rs1_field = instr[19:15];
    assign rs2_field = instr[24:20];
    assign rd_field  = instr[11:7];

    always_comb begin
        // defaults cover unknown opcodes with no sources and no destination
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        has_dest = 1'b0;
        uimm     = '0;
        case (op_class)
            // two sources, one result
            OPC_R, OPC_R_WORD: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                has_dest = 1'b1;
            end
            // one source and a 12-bit immediate
            OPC_JALR, OPC_LOAD, OPC_I_ARITH, OPC_I_WORD: begin
                use_rs1  = 1'b1;
                has_dest = 1'b1;
            end
            // csr ops read rs1 and may write rd
            OPC_SYSTEM: begin
                use_rs1  = 1'b1;
                has_dest = 1'b1;
            end
            // store data and branch compare both need rs2
            // rd field holds immediate bits here and names no register
            OPC_STORE, OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            // upper 20 bits straight through
            OPC_LUI, OPC_AUIPC: begin
                has_dest = 1'b1;
                uimm     = instr[31:12];
            end
            // jal offset reordered to natural bit order
            OPC_JAL: begin
                has_dest = 1'b1;
                uimm     = {instr[31], instr[19:12], instr[20], instr[30:21]};
            end
            // fence carries nothing the register side cares about
            default: begin
            end
        endcase
    end

    // unused sources read as x0 so they never raise a hazard
    assign rs1  = use_rs1 ? rs1_field : '0;
    assign rs2  = use_rs2 ? rs2_field : '0;
    assign dest = has_dest ? rd_field : '0;

    // funct3 on top of the major opcode
    assign op_key = {instr[14:12], instr[OPC_W-1:0]};

    // i-type immediate position
    // execute reassembles the store and branch pieces
    assign imm = instr[31:20];

endmodule

// File: design/decode_pkg.sv
// decode stage shared definitions
package decode_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int INSTR_W    = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    // operation key is funct3 stacked on the major opcode
    localparam int OPC_W      = 7;
    localparam int FUNCT3_W   = 3;
    localparam int OP_KEY_W   = FUNCT3_W + OPC_W;

    // immediate fields as they sit in the instruction
    localparam int IMM_W      = 12;
    localparam int UIMM_W     = 20;

    // basic words
    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OP_KEY_W-1:0]   op_key_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [UIMM_W-1:0]     uimm_t;

    // major opcode classes, values are the rv64i encodings
    typedef enum logic [OPC_W-1:0] {
        // register-register
        OPC_R       = 7'b0110011,
        OPC_R_WORD  = 7'b0111011,
        // register-immediate and jumps through a register
        OPC_JALR    = 7'b1100111,
        OPC_LOAD    = 7'b0000011,
        OPC_I_ARITH = 7'b0010011,
        OPC_I_WORD  = 7'b0011011,
        // memory writes and conditional branches
        OPC_STORE   = 7'b0100011,
        OPC_BRANCH  = 7'b1100011,
        // upper immediate forms
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        // ordering and csr / environment calls
        OPC_FENCE   = 7'b0001111,
        OPC_SYSTEM  = 7'b1110011
    } opcode_class_t;

    // squashed slot looks like a plain fence with funct3 zero
    // execute treats it as a no-op
    localparam op_key_t BUBBLE_OP = {3'b000, OPC_FENCE};

endpackage
